//--- vlog.f
+incdir+hdl
hdl/hba_bus_pkg.sv
hdl/hba_periph_pkg.sv
hdl/hba_master_ctrl.sv
hdl/hba_basicio.sv
hdl/hba_motor.sv
hdl/hba_system.sv
verification/hba_clk_gen.sv
verification/hba_system_chk.sv
verification/tb_hba_system.sv

//--- Makefile
# Verilator build and run of the HBA peripheral system testbench.
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_hba_system
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
PASS_MSG  := TEST RESULT: PASS

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_hba_system.sv
/*
 * Testbench for hba_system. Random stimulus from a fixed seed, checked
 * against a register model of slots 1 and 3 kept here.
 * Inputs change on the rising edge, outputs are sampled on the falling edge.
 * Estop and button changes are driven only between commands.
 */
`timescale 1ns/100ps
`include "hba_macros.svh"

module tb_hba_system;

    import hba_bus_pkg::*;
    import hba_periph_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_LED      = 20;
    localparam int N_BTN      = 4;
    localparam int N_PWM      = 3;
    localparam int N_MIX      = 300;
    localparam int PWM_PERIOD = 1 << `HBA_PWM_WIDTH;
    localparam int MAX_LAT    = `HBA_ACK_TIMEOUT + 4; // Worst command length, cycles.
    localparam int N_CMDS     = 2 * N_LED + 3 * N_BTN + 4 * N_PWM + 8 + 20 + N_MIX;
    localparam int RUN_CYCLES = N_CMDS * MAX_LAT + (N_PWM + 1) * PWM_PERIOD + 100;

    logic                         clk;
    logic                         reset;
    logic                         cmd_valid;
    hba_op_t                      cmd_op;
    logic [`HBA_ADDR_WIDTH-1:0]   cmd_addr;
    logic [`HBA_DBUS_WIDTH-1:0]   cmd_wdata;
    logic                         busy;
    logic                         rsp_valid;
    logic [`HBA_DBUS_WIDTH-1:0]   rsp_rdata;
    logic                         rsp_err;
    logic                         intr;
    logic [7:0]                   basicio_button;
    logic [7:0]                   basicio_led;
    logic                         motor_estop;
    logic [1:0]                   motor_pwm;
    logic [1:0]                   motor_dir;
    logic [1:0]                   motor_float_n;

    // Register model.
    logic [7:0] m_led, m_btn, m_bio_status;
    logic [7:0] m_duty [2];
    logic [1:0] m_dir, m_enable;
    logic       m_mot_status;

    int n_checks, n_errors, errors_before, n_tests, n_failed_tests;

    hba_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) hba_clk_gen_i (.clk(clk), .reset(reset));

    hba_system hba_system_i (.*);

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    function automatic logic [11:0] reg_addr(input logic [3:0] slot, input logic [7:0] off);
        return {slot, off};
    endfunction

    function automatic logic slot_present(input logic [11:0] addr);
        return (addr[11:8] == SLOT_BASICIO) || (addr[11:8] == SLOT_MOTOR);
    endfunction

    // Read value from the register map. Empty slots and unmapped offsets give 0.
    function automatic logic [7:0] expected_read(input logic [11:0] addr);
        if (addr[11:8] == SLOT_BASICIO) begin
            case (addr[7:0])
                BIO_LED:    return m_led;
                BIO_BUTTON: return m_btn;
                BIO_STATUS: return m_bio_status;
                default:    return 8'h00;
            endcase
        end else if (addr[11:8] == SLOT_MOTOR) begin
            case (addr[7:0])
                MOT_DUTY_L: return m_duty[0];
                MOT_DUTY_R: return m_duty[1];
                MOT_DIR:    return {6'b0, m_dir};
                MOT_ENABLE: return {6'b0, m_enable};
                MOT_STATUS: return {7'b0, m_mot_status};
                default:    return 8'h00;
            endcase
        end
        return 8'h00;
    endfunction

    function automatic void update_model(input hba_op_t op, input logic [11:0] addr,
                                         input logic [7:0] wdata);
        if (addr[11:8] == SLOT_BASICIO) begin
            if (op == HBA_OP_WRITE && addr[7:0] == BIO_LED) m_led = wdata;
            if (op == HBA_OP_READ && addr[7:0] == BIO_STATUS) m_bio_status = 8'h00; // Clear on read.
        end else if (addr[11:8] == SLOT_MOTOR) begin
            if (op == HBA_OP_READ) begin
                if (addr[7:0] == MOT_STATUS) m_mot_status = 1'b0;
            end else begin
                case (addr[7:0])
                    MOT_DUTY_L: m_duty[0] = wdata;
                    MOT_DUTY_R: m_duty[1] = wdata;
                    MOT_DIR:    m_dir = wdata[1:0];
                    MOT_ENABLE: m_enable = wdata[1:0];
                    default:    ; // Read-only or unmapped.
                endcase
            end
        end
    endfunction

    // One host command. lat counts edges from the taking edge to the response.
    task automatic run_cmd(input hba_op_t op, input logic [11:0] addr, input logic [7:0] wdata,
                           output logic [7:0] rdata, output logic err, output int lat);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_wdata <= wdata;
        @(posedge clk);               // Taking edge.
        cmd_valid <= 1'b0;
        lat = 0;
        @(negedge clk);
        check("busy", 32'(busy), 32'(1));
        while (!rsp_valid && lat <= MAX_LAT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        assert (rsp_valid) else begin
            $display("No response to the command at address %0h within %0d cycles", addr, MAX_LAT);
            n_errors++;
        end
        rdata = rsp_rdata;
        err   = rsp_err;
    endtask

    // Command checked against the model: latency, error flag and read data.
    task automatic access(input hba_op_t op, input logic [11:0] addr, input logic [7:0] wdata);
        logic [7:0] rdata;
        logic [7:0] exp_data;
        logic       err;
        logic       hit;
        int         lat;
        hit      = slot_present(addr);
        exp_data = expected_read(addr);
        run_cmd(op, addr, wdata, rdata, err, lat);
        check("latency", 32'(lat), 32'(hit ? 2 : `HBA_ACK_TIMEOUT + 1));
        check("rsp_err", 32'(err), 32'(!hit));
        if (op == HBA_OP_READ) check("rsp_rdata", 32'(rdata), 32'(exp_data));
        update_model(op, addr, wdata);
    endtask

    task automatic end_test(input string name);
        if (n_errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, n_errors - errors_before);
            n_failed_tests++;
        end
        n_tests++;
        errors_before = n_errors;
    endtask

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", 2 * RUN_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [7:0] data;
        logic [7:0] new_btn;
        logic [3:0] slot;
        int         high_cnt [2];
        int         bad_cycles;
        int         rsp_count;
        void'($urandom(87637));
        cmd_valid      = 1'b0;
        cmd_op         = HBA_OP_WRITE;
        cmd_addr       = '0;
        cmd_wdata      = '0;
        basicio_button = '0;
        motor_estop    = 1'b0;
        m_led = '0;
        m_btn = '0;
        m_bio_status = '0;
        m_duty[0] = '0;
        m_duty[1] = '0;
        m_dir = '0;
        m_enable = '0;
        m_mot_status = 1'b0;
        @(negedge reset);
        @(posedge clk);

        // LED write and read back.
        for (int i = 0; i < N_LED; i++) begin
            access(HBA_OP_WRITE, reg_addr(SLOT_BASICIO, BIO_LED), 8'($urandom));
            check("basicio_led", 32'(basicio_led), 32'(m_led));
            access(HBA_OP_READ, reg_addr(SLOT_BASICIO, BIO_LED), 8'h00);
        end
        end_test("led_register");

        // Button change, interrupt, clear on read.
        for (int i = 0; i < N_BTN; i++) begin
            do new_btn = 8'($urandom); while (new_btn == m_btn);
            @(posedge clk);
            basicio_button <= new_btn;
            repeat (2) @(posedge clk);
            @(negedge clk);
            check("intr", 32'(intr), 32'(0)); // Still in the synchronizer.
            @(posedge clk);
            @(negedge clk);
            check("intr", 32'(intr), 32'(1)); // Third edge.
            m_bio_status = m_btn ^ new_btn;
            m_btn        = new_btn;
            access(HBA_OP_READ, reg_addr(SLOT_BASICIO, BIO_BUTTON), 8'h00);
            access(HBA_OP_READ, reg_addr(SLOT_BASICIO, BIO_STATUS), 8'h00);
            access(HBA_OP_READ, reg_addr(SLOT_BASICIO, BIO_STATUS), 8'h00);
            check("intr", 32'(intr), 32'(0));
        end
        end_test("buttons_interrupt");

        // PWM duty over one full period, plus dir and enable pins.
        for (int i = 0; i < N_PWM; i++) begin
            access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_DUTY_L), (i == 0) ? 8'h00 : 8'($urandom));
            access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_DUTY_R), (i == 0) ? 8'hff : 8'($urandom));
            access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_DIR), 8'($urandom));
            access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_ENABLE), 8'($urandom));
            high_cnt[0] = 0;
            high_cnt[1] = 0;
            repeat (PWM_PERIOD) begin
                @(negedge clk);
                high_cnt[0] += int'(motor_pwm[0]);
                high_cnt[1] += int'(motor_pwm[1]);
            end
            check("motor_pwm[0] high cycles", 32'(high_cnt[0]), 32'(m_duty[0]));
            check("motor_pwm[1] high cycles", 32'(high_cnt[1]), 32'(m_duty[1]));
            check("motor_dir", 32'(motor_dir), 32'(m_dir));
            check("motor_float_n", 32'(motor_float_n), 32'(m_enable));
        end
        end_test("pwm_dir_enable");

        // Emergency stop while both channels run.
        access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_DUTY_L), 8'($urandom_range(255, 1)));
        access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_DUTY_R), 8'($urandom_range(255, 1)));
        access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, MOT_ENABLE), 8'h03);
        @(posedge clk);
        motor_estop <= 1'b1;
        @(posedge clk);
        motor_estop <= 1'b0;
        repeat (4) @(posedge clk);    // Synchronizer plus PWM register.
        bad_cycles = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            if (motor_pwm != 2'b00 || motor_float_n != 2'b00) bad_cycles++;
        end
        check("motor_pwm/motor_float_n active cycles after estop", 32'(bad_cycles), 32'(0));
        m_duty[0]    = '0;
        m_duty[1]    = '0;
        m_enable     = '0;
        m_mot_status = 1'b1;
        check("intr", 32'(intr), 32'(1));
        access(HBA_OP_READ, reg_addr(SLOT_MOTOR, MOT_DUTY_L), 8'h00);
        access(HBA_OP_READ, reg_addr(SLOT_MOTOR, MOT_DUTY_R), 8'h00);
        access(HBA_OP_READ, reg_addr(SLOT_MOTOR, MOT_ENABLE), 8'h00);
        check("intr", 32'(intr), 32'(1));
        access(HBA_OP_READ, reg_addr(SLOT_MOTOR, MOT_STATUS), 8'h00);
        access(HBA_OP_READ, reg_addr(SLOT_MOTOR, MOT_STATUS), 8'h00);
        check("intr", 32'(intr), 32'(0));
        end_test("emergency_stop");

        // Empty slots time out, unmapped offsets read 0.
        for (int s = 0; s < 16; s++) begin
            slot = 4'(s);
            if (!slot_present(reg_addr(slot, 8'h00))) begin
                access(s[0] ? HBA_OP_READ : HBA_OP_WRITE, reg_addr(slot, 8'($urandom)), 8'($urandom));
            end
        end
        access(HBA_OP_READ, reg_addr(SLOT_BASICIO, 8'($urandom_range(255, 3))), 8'h00);
        access(HBA_OP_WRITE, reg_addr(SLOT_BASICIO, 8'($urandom_range(255, 3))), 8'($urandom));
        access(HBA_OP_READ, reg_addr(SLOT_MOTOR, 8'($urandom_range(255, 5))), 8'h00);
        access(HBA_OP_WRITE, reg_addr(SLOT_MOTOR, 8'($urandom_range(255, 5))), 8'($urandom));
        // Second strobe one cycle into a transfer.
        data = 8'($urandom);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= HBA_OP_WRITE;
        cmd_addr  <= reg_addr(SLOT_BASICIO, BIO_LED);
        cmd_wdata <= data;
        @(posedge clk);
        cmd_wdata <= ~data;
        @(posedge clk);               // Strobe seen while busy.
        cmd_valid <= 1'b0;
        rsp_count = 0;
        repeat (2 * MAX_LAT) begin
            @(negedge clk);
            rsp_count += int'(rsp_valid);
        end
        check("rsp_valid pulses", 32'(rsp_count), 32'(1));
        m_led = data;
        check("basicio_led", 32'(basicio_led), 32'(m_led));
        access(HBA_OP_READ, reg_addr(SLOT_BASICIO, BIO_LED), 8'h00);
        end_test("address_decode");

        // Random mix over both slots and some empty ones.
        for (int i = 0; i < N_MIX; i++) begin
            case ($urandom_range(9, 0))
                0:          slot = 4'($urandom);
                1, 2, 3, 4: slot = SLOT_BASICIO;
                default:    slot = SLOT_MOTOR;
            endcase
            access($urandom_range(1, 0) ? HBA_OP_READ : HBA_OP_WRITE,
                   reg_addr(slot, 8'($urandom_range(5, 0))), 8'($urandom));
        end
        check("basicio_led", 32'(basicio_led), 32'(m_led));
        check("motor_dir", 32'(motor_dir), 32'(m_dir));
        check("motor_float_n", 32'(motor_float_n), 32'(m_enable));
        end_test("random_mix");

        if (hba_system_i.hba_master_ctrl_i.hba_system_chk_i.fail_count != 0) begin
            $display("Bus protocol assertions failed %0d times",
                     hba_system_i.hba_master_ctrl_i.hba_system_chk_i.fail_count);
            n_errors += hba_system_i.hba_master_ctrl_i.hba_system_chk_i.fail_count;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/hba_system_chk.sv
/*
 * Bus protocol assertions for hba_master_ctrl, attached by bind.
 * Disabled while reset is high. fail_count is read by the testbench.
 */
`timescale 1ns/100ps
`include "hba_macros.svh"

module hba_system_chk (
    input logic                         clk,
    input logic                         reset,
    input logic                         hba_select,
    input logic [`HBA_ADDR_WIDTH-1:0]   hba_abus,
    input logic [1:0]                   xferack_slave,
    input logic                         rsp_valid
);

    int fail_count = 0;

    // Select comes up only from idle, never straight out of a response.
    select_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(hba_select) |-> !$past(rsp_valid))
        else begin
            fail_count++;
            $error("select rose while a response was pending");
        end

    ack_single: assert property (@(posedge clk) disable iff (reset)
        (|xferack_slave) |=> !(|xferack_slave))
        else begin
            fail_count++;
            $error("acknowledge high for two cycles in a row");
        end

    rsp_single: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid)
        else begin
            fail_count++;
            $error("response strobe longer than one cycle");
        end

    // Address held for the whole transfer.
    abus_stable: assert property (@(posedge clk) disable iff (reset)
        hba_select |=> (!hba_select || $stable(hba_abus)))
        else begin
            fail_count++;
            $error("address changed while select was high");
        end

endmodule

bind hba_master_ctrl hba_system_chk hba_system_chk_i (
    .clk(clk), .reset(reset), .hba_select(hba_select), .hba_abus(hba_abus),
    .xferack_slave(xferack_slave), .rsp_valid(rsp_valid)
);

//--- verification/hba_clk_gen.sv
/*
 * Testbench clock and reset. Reset is high from time 0 and drops
 * on the edge after RESET_CYCLES rising edges.
 */
`timescale 1ns/100ps

module hba_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0; // Released on a rising edge.
    end

endmodule

//--- hdl/hba_system.sv
/*
 * HBA system top. One host-driven master, basic I/O in slot 1 and the
 * motor peripheral in slot 3. All other slots are empty and time out.
 */
`timescale 1ns/100ps
`include "hba_macros.svh"

module hba_system (
    input  logic                         clk,
    input  logic                         reset,

    // Host command port.
    input  logic                         cmd_valid,
    input  hba_bus_pkg::hba_op_t         cmd_op,
    input  logic [`HBA_ADDR_WIDTH-1:0]   cmd_addr,
    input  logic [`HBA_DBUS_WIDTH-1:0]   cmd_wdata,
    output logic                         busy,
    output logic                         rsp_valid,
    output logic [`HBA_DBUS_WIDTH-1:0]   rsp_rdata,
    output logic                         rsp_err,
    output logic                         intr,

    // Slot 1 pins.
    input  logic [7:0]                   basicio_button,
    output logic [7:0]                   basicio_led,

    // Slot 3 pins.
    input  logic                         motor_estop,
    output logic [1:0]                   motor_pwm,
    output logic [1:0]                   motor_dir,
    output logic [1:0]                   motor_float_n
);

    import hba_periph_pkg::*;

    logic                        hba_select;
    logic                        hba_rnw;      // 1 = read.
    logic [`HBA_ADDR_WIDTH-1:0]  hba_abus;
    logic [`HBA_DBUS_WIDTH-1:0]  hba_dbus;     // Write data.
    logic [1:0]                  hba_xferack_slave; // [0] basic I/O, [1] motor.
    logic [1:0]                  slave_interrupt;
    logic [`HBA_DBUS_WIDTH-1:0]  hba_dbus_slave1;
    logic [`HBA_DBUS_WIDTH-1:0]  hba_dbus_slave3;

    hba_master_ctrl hba_master_ctrl_i (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .busy(busy), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
        .intr(intr),
        .xferack_slave(hba_xferack_slave),
        .dbus_slave1(hba_dbus_slave1),
        .dbus_slave3(hba_dbus_slave3),
        .slave_interrupt(slave_interrupt),
        .hba_select(hba_select), .hba_rnw(hba_rnw), .hba_abus(hba_abus), .hba_dbus(hba_dbus)
    );

    hba_basicio #(.PERIPH_ADDR(SLOT_BASICIO)) hba_basicio_i (
        .clk(clk), .reset(reset),
        .hba_select(hba_select), .hba_rnw(hba_rnw), .hba_abus(hba_abus), .hba_dbus(hba_dbus),
        .basicio_button(basicio_button),
        .hba_dbus_slave(hba_dbus_slave1),
        .hba_xferack_slave(hba_xferack_slave[0]),
        .slave_interrupt(slave_interrupt[0]),
        .basicio_led(basicio_led)
    );

    hba_motor #(.PERIPH_ADDR(SLOT_MOTOR)) hba_motor_i (
        .clk(clk), .reset(reset),
        .hba_select(hba_select), .hba_rnw(hba_rnw), .hba_abus(hba_abus), .hba_dbus(hba_dbus),
        .motor_estop(motor_estop),
        .hba_dbus_slave(hba_dbus_slave3),
        .hba_xferack_slave(hba_xferack_slave[1]),
        .slave_interrupt(slave_interrupt[1]),
        .motor_pwm(motor_pwm), .motor_dir(motor_dir), .motor_float_n(motor_float_n)
    );

endmodule

//--- hdl/hba_motor.sv
/*
 * Two-channel PWM motor slave. Channel 0 is left, channel 1 is right.
 * PWM period is 2**HBA_PWM_WIDTH cycles; output is high while count < duty.
 * Estop is synchronized and clears duties and enables on the third edge.
 * The estop event stays in MOT_STATUS until read.
 */
`timescale 1ns/100ps
`include "hba_macros.svh"

module hba_motor #(
    parameter hba_periph_pkg::hba_slot_t PERIPH_ADDR = hba_periph_pkg::SLOT_MOTOR
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         hba_select,
    input  logic                         hba_rnw,
    input  logic [`HBA_ADDR_WIDTH-1:0]   hba_abus,
    input  logic [`HBA_DBUS_WIDTH-1:0]   hba_dbus,
    input  logic                         motor_estop,
    output logic [`HBA_DBUS_WIDTH-1:0]   hba_dbus_slave,
    output logic                         hba_xferack_slave,
    output logic                         slave_interrupt,
    output logic [1:0]                   motor_pwm,
    output logic [1:0]                   motor_dir,
    output logic [1:0]                   motor_float_n
);

    import hba_periph_pkg::*;

    logic [`HBA_REG_ADDR_WIDTH-1:0]   reg_off;
    logic                             ack_next;
    logic                             wr_en;
    logic                             rd_en;
    logic [`HBA_DBUS_WIDTH-1:0]       rd_data;
    logic [1:0][`HBA_PWM_WIDTH-1:0]   duty;      // Per-channel duty.
    logic [1:0]                       enable_q;
    logic                             status_q;  // Estop event.
    logic [`HBA_PWM_WIDTH-1:0]        pwm_cnt;   // Free running.
    logic                             estop_meta;
    logic                             estop_sync;

    assign reg_off  = hba_abus[`HBA_REG_ADDR_WIDTH-1:0];
    assign ack_next = hba_select && !hba_xferack_slave &&
                      (hba_abus[`HBA_ADDR_WIDTH-1 -: `HBA_PERIPH_ADDR_WIDTH] == PERIPH_ADDR);
    assign wr_en    = ack_next && !hba_rnw;
    assign rd_en    = ack_next && hba_rnw;

    always_comb begin
        case (reg_off)
            MOT_DUTY_L: rd_data = duty[0];
            MOT_DUTY_R: rd_data = duty[1];
            MOT_DIR:    rd_data = {6'b0, motor_dir};
            MOT_ENABLE: rd_data = {6'b0, enable_q};
            MOT_STATUS: rd_data = {7'b0, status_q};
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hba_xferack_slave <= 1'b0;
            hba_dbus_slave    <= '0;
            duty              <= '0;
            motor_dir         <= '0;
            enable_q          <= '0;
            status_q          <= 1'b0;
        end else begin
            hba_xferack_slave <= ack_next;
            hba_dbus_slave    <= rd_en ? rd_data : '0;
            if (wr_en) begin
                case (reg_off)
                    MOT_DUTY_L: duty[0]   <= hba_dbus;
                    MOT_DUTY_R: duty[1]   <= hba_dbus;
                    MOT_DIR:    motor_dir <= hba_dbus[1:0];
                    MOT_ENABLE: enable_q  <= hba_dbus[1:0];
                    default:    ;         // Read-only or unmapped.
                endcase
            end
            if (estop_sync) begin        // Estop overrides any bus write.
                duty     <= '0;
                enable_q <= '0;
            end
            status_q <= estop_sync || (status_q && !(rd_en && reg_off == MOT_STATUS));
        end
    end

    // Estop synchronizer and PWM generation.
    always_ff @(posedge clk) begin
        if (reset) begin
            estop_meta <= 1'b0;
            estop_sync <= 1'b0;
            pwm_cnt    <= '0;
            motor_pwm  <= '0;
        end else begin
            estop_meta <= motor_estop;
            estop_sync <= estop_meta;
            pwm_cnt    <= pwm_cnt + 1'b1;
            for (int i = 0; i < 2; i++) begin
                motor_pwm[i] <= (pwm_cnt < duty[i]); // One cycle behind the duty.
            end
        end
    end

    assign motor_float_n   = enable_q & {2{!estop_sync}};
    assign slave_interrupt = status_q;

endmodule

//--- hdl/hba_basicio.sv
/*
 * Basic I/O slave with an LED register and eight synchronized buttons.
 * Button changes set sticky status bits; the interrupt stays up until
 * BIO_STATUS is read. Buttons show up three edges after they change.
 */
`timescale 1ns/100ps
`include "hba_macros.svh"

module hba_basicio #(
    parameter hba_periph_pkg::hba_slot_t PERIPH_ADDR = hba_periph_pkg::SLOT_BASICIO
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         hba_select,
    input  logic                         hba_rnw,
    input  logic [`HBA_ADDR_WIDTH-1:0]   hba_abus,
    input  logic [`HBA_DBUS_WIDTH-1:0]   hba_dbus,
    input  logic [7:0]                   basicio_button,
    output logic [`HBA_DBUS_WIDTH-1:0]   hba_dbus_slave,
    output logic                         hba_xferack_slave,
    output logic                         slave_interrupt,
    output logic [7:0]                   basicio_led
);

    import hba_periph_pkg::*;

    logic [`HBA_REG_ADDR_WIDTH-1:0] reg_off;
    logic                           ack_next;  // First cycle of select on our slot.
    logic                           wr_en;
    logic                           rd_en;
    logic [`HBA_DBUS_WIDTH-1:0]     rd_data;
    logic [7:0]                     btn_meta;
    logic [7:0]                     btn_sync;
    logic [7:0]                     btn_reg;   // Value seen by the bus.
    logic [7:0]                     status;    // Sticky change bits.

    assign reg_off  = hba_abus[`HBA_REG_ADDR_WIDTH-1:0];
    assign ack_next = hba_select && !hba_xferack_slave &&
                      (hba_abus[`HBA_ADDR_WIDTH-1 -: `HBA_PERIPH_ADDR_WIDTH] == PERIPH_ADDR);
    assign wr_en    = ack_next && !hba_rnw;
    assign rd_en    = ack_next && hba_rnw;

    always_comb begin
        case (reg_off)
            BIO_LED:    rd_data = basicio_led;
            BIO_BUTTON: rd_data = btn_reg;
            BIO_STATUS: rd_data = status;
            default:    rd_data = '0; // Unmapped offset.
        endcase
    end

    // Bus side. Ack is a single cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            hba_xferack_slave <= 1'b0;
            hba_dbus_slave    <= '0;
            basicio_led       <= '0;
        end else begin
            hba_xferack_slave <= ack_next;
            hba_dbus_slave    <= rd_en ? rd_data : '0;
            if (wr_en && (reg_off == BIO_LED)) basicio_led <= hba_dbus;
        end
    end

    // Two-flop synchronizer, then the register stage used for change detect.
    always_ff @(posedge clk) begin
        if (reset) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_reg  <= '0;
            status   <= '0;
        end else begin
            btn_meta <= basicio_button;
            btn_sync <= btn_meta;
            btn_reg  <= btn_sync;
            // New changes win over a clearing read.
            status   <= ((rd_en && reg_off == BIO_STATUS) ? '0 : status) | (btn_sync ^ btn_reg);
        end
    end

    assign slave_interrupt = |status;

endmodule

//--- hdl/hba_master_ctrl.sv
/*
 * Single-master HBA controller behind a host command port.
 * A command is taken only while busy is low; commands during busy are dropped.
 * A hit answers two edges after the command, a miss after HBA_ACK_TIMEOUT + 1.
 * Slaves must drive zero on data and ack when they are not acknowledging.
 */
`timescale 1ns/100ps
`include "hba_macros.svh"

module hba_master_ctrl (
    input  logic                         clk,
    input  logic                         reset,

    // Host command port.
    input  logic                         cmd_valid,
    input  hba_bus_pkg::hba_op_t         cmd_op,
    input  logic [`HBA_ADDR_WIDTH-1:0]   cmd_addr,
    input  logic [`HBA_DBUS_WIDTH-1:0]   cmd_wdata,
    output logic                         busy,
    output logic                         rsp_valid,
    output logic [`HBA_DBUS_WIDTH-1:0]   rsp_rdata,
    output logic                         rsp_err,
    output logic                         intr,

    // Slave returns.
    input  logic [1:0]                   xferack_slave,
    input  logic [`HBA_DBUS_WIDTH-1:0]   dbus_slave1,
    input  logic [`HBA_DBUS_WIDTH-1:0]   dbus_slave3,
    input  logic [1:0]                   slave_interrupt,

    // Bus drive.
    output logic                         hba_select,
    output logic                         hba_rnw,
    output logic [`HBA_ADDR_WIDTH-1:0]   hba_abus,
    output logic [`HBA_DBUS_WIDTH-1:0]   hba_dbus
);

    import hba_bus_pkg::*;

    localparam int CNT_W = $clog2(`HBA_ACK_TIMEOUT + 1);

    hba_state_t                  state;
    logic [CNT_W-1:0]            wait_cnt;    // Cycles spent in ST_SELECT.
    logic                        xferack;     // Any slave acknowledging.
    logic [`HBA_DBUS_WIDTH-1:0]  dbus_or;     // Combined slave read data.
    logic                        cmd_take;

    // Idle slaves drive zero, so a plain OR merges them.
    assign xferack = |xferack_slave;
    assign dbus_or = dbus_slave1 | dbus_slave3;
    assign intr    = |slave_interrupt;

    assign cmd_take   = cmd_valid && (state == ST_IDLE);
    assign busy       = (state != ST_IDLE);  // Up from taking edge to end of response.
    assign hba_select = (state == ST_SELECT);
    assign rsp_valid  = (state == ST_RESP);   // One cycle only.

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
            rsp_err  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_take) begin
                        state    <= ST_SELECT;
                        wait_cnt <= '0;
                    end
                end
                ST_SELECT: begin
                    if (xferack) begin
                        state   <= ST_RESP;
                        rsp_err <= 1'b0;
                    end else if (wait_cnt == CNT_W'(`HBA_ACK_TIMEOUT)) begin
                        state   <= ST_RESP; // Nobody home in this slot.
                        rsp_err <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_RESP: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command payload, held on the bus for the whole transfer.
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            hba_rnw  <= (cmd_op == HBA_OP_READ);
            hba_abus <= cmd_addr;
            hba_dbus <= cmd_wdata;
        end
    end

    // Read data capture. Stays 0 on a timeout.
    always_ff @(posedge clk) begin
        if (state == ST_SELECT) begin
            rsp_rdata <= xferack ? dbus_or : '0;
        end
    end

endmodule

//--- hdl/hba_periph_pkg.sv
/*
 * Register map of the HBA peripherals.
 * Only slots 1 and 3 are populated. Other slots time out on the bus.
 * Offsets outside a map acknowledge, read as 0 and ignore writes.
 */
`include "hba_macros.svh"

package hba_periph_pkg;

    // Populated slot numbers.
    typedef enum logic [`HBA_PERIPH_ADDR_WIDTH-1:0] {
        SLOT_BASICIO = 4'd1,
        SLOT_MOTOR   = 4'd3
    } hba_slot_t;

    // Basic I/O registers.
    typedef enum logic [`HBA_REG_ADDR_WIDTH-1:0] {
        BIO_LED    = 8'd0, // Read/write.
        BIO_BUTTON = 8'd1, // Read only.
        BIO_STATUS = 8'd2  // Change bits, cleared on read.
    } basicio_reg_t;

    // Motor registers.
    typedef enum logic [`HBA_REG_ADDR_WIDTH-1:0] {
        MOT_DUTY_L = 8'd0,
        MOT_DUTY_R = 8'd1,
        MOT_DIR    = 8'd2, // Bits 1:0.
        MOT_ENABLE = 8'd3, // Bits 1:0.
        MOT_STATUS = 8'd4  // Bit 0 estop event, cleared on read.
    } motor_reg_t;

endpackage

//--- hdl/hba_bus_pkg.sv
/*
 * HBA bus protocol types for the single-master controller.
 * The opcode encoding matches hba_rnw, so read is 1 and write is 0.
 */
package hba_bus_pkg;

    // Transfer opcode from the host port.
    typedef enum logic {
        HBA_OP_WRITE = 1'b0,
        HBA_OP_READ  = 1'b1
    } hba_op_t;

    // Control FSM states.
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0, // Waiting for a command.
        ST_SELECT = 2'd1, // Bus held, waiting for ack or timeout.
        ST_RESP   = 2'd2  // One-cycle response to the host.
    } hba_state_t;

endpackage

//--- hdl/hba_macros.svh
/*
 * Shared widths and constants for the HBA peripheral system.
 * The address splits into a 4-bit slot and an 8-bit register offset.
 * The timeout counts wait cycles after select rises, before an error response.
 */
`ifndef HBA_MACROS_SVH
`define HBA_MACROS_SVH

// Bus widths.
`define HBA_DBUS_WIDTH 8
`define HBA_PERIPH_ADDR_WIDTH 4
`define HBA_REG_ADDR_WIDTH 8
`define HBA_ADDR_WIDTH 12 // Slot in the upper 4 bits.

// Cycles with no acknowledge before the transfer fails.
`define HBA_ACK_TIMEOUT 8

// PWM counter width. The period is 2**width cycles.
`define HBA_PWM_WIDTH 8

`endif
